//--- common/rvPkg.sv
`default_nettype none

package rvPkg;

    typedef enum logic [6:0] {
        opOp     = 7'b0110011,
        opOpImm  = 7'b0010011,
        opBranch = 7'b1100011,
        opJalr   = 7'b1100111
    } opcode_e;

    // Base integer ops, shared by the Zbb/Zbs forms with the same funct3
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;   // Also rol, sext, bclr, binv, bset
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;   // Also xnor, zext.h
    localparam logic [2:0] f3Sr     = 3'b101;   // srl, sra, ror, bext
    localparam logic [2:0] f3Or     = 3'b110;   // Also orn
    localparam logic [2:0] f3And    = 3'b111;   // Also andn
    localparam logic [2:0] f3Jalr   = 3'b000;

    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // Zba shift-and-add
    localparam logic [2:0] f3Sh1add = 3'b010;
    localparam logic [2:0] f3Sh2add = 3'b100;
    localparam logic [2:0] f3Sh3add = 3'b110;

    // Zbb min/max
    localparam logic [2:0] f3Min  = 3'b100;
    localparam logic [2:0] f3Minu = 3'b101;
    localparam logic [2:0] f3Max  = 3'b110;
    localparam logic [2:0] f3Maxu = 3'b111;

    localparam logic [6:0] f7Base   = 7'b0000000;
    localparam logic [6:0] f7Alt    = 7'b0100000;   // sub, sra
    localparam logic [6:0] f7Zba    = 7'b0010000;
    localparam logic [6:0] f7MinMax = 7'b0000101;
    localparam logic [6:0] f7Negate = 7'b0100000;   // andn, orn, xnor
    localparam logic [6:0] f7Rotate = 7'b0110000;   // rol, ror, sext
    localparam logic [6:0] f7Zext   = 7'b0000100;
    localparam logic [6:0] f7Bclr   = 7'b0100100;
    localparam logic [6:0] f7Binv   = 7'b0110100;
    localparam logic [6:0] f7Bset   = 7'b0010100;
    localparam logic [6:0] f7Bext   = 7'b0100100;

    // Unary Zbb forms are picked by the rs2 field
    localparam logic [4:0] rs2SextB = 5'b00100;
    localparam logic [4:0] rs2SextH = 5'b00101;
    localparam logic [4:0] rs2Zext  = 5'b00000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_s;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_s;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        logic [6:0] opcode;
    } bType_s;

    typedef union packed {
        rType_s r;
        iType_s i;
        bType_s b;
    } rvInstr_u;

endpackage

`default_nettype wire

//--- common/aluPkg.sv
`default_nettype none

package aluPkg;

    import rvPkg::*;

    // Sparse control codes, immediate Zbs forms folded in
    typedef enum logic [5:0] {
        aluAdd   = 6'd0,
        aluSub   = 6'd1,
        aluAnd   = 6'd2,
        aluOr    = 6'd3,
        aluXor   = 6'd4,
        aluSlt   = 6'd5,
        aluSll   = 6'd6,
        aluSra   = 6'd7,
        aluSge   = 6'd8,
        aluEq    = 6'd9,
        aluNe    = 6'd10,
        aluSrl   = 6'd11,
        aluSltu  = 6'd12,
        aluSgeu  = 6'd13,
        aluJalr  = 6'd14,
        aluShadd = 6'd15,
        aluAndn  = 6'd16,
        aluOrn   = 6'd17,
        aluXnor  = 6'd18,
        aluMax   = 6'd19,
        aluMin   = 6'd20,
        aluSext  = 6'd21,
        aluZext  = 6'd22,
        aluRol   = 6'd23,
        aluRor   = 6'd24,
        aluBclr  = 6'd25,
        aluBext  = 6'd27,
        aluBinv  = 6'd29,
        aluBset  = 6'd31
    } aluOp_e;

    typedef struct packed {
        rvInstr_u    instr;
        logic [31:0] rs1Val;
        logic [31:0] rs2Val;
    } execIn_s;

    typedef struct packed {
        logic [31:0] result;
        logic        branchTaken;
        logic        illegal;
    } execOut_s;

    typedef struct packed {
        aluOp_e      aluOp;
        logic [2:0]  funct3;     // Variant select for shadd, min, max
        logic        useImm;
        logic [31:0] imm;
        logic        isBranch;
        logic        illegal;
    } decoded_s;

endpackage

`default_nettype wire

//--- decode/aluDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module aluDecoder (
    input  rvPkg::rvInstr_u  instr,
    output aluPkg::decoded_s dec
);

    import rvPkg::*;
    import aluPkg::*;

    logic [6:0]  f7;
    logic [2:0]  f3;
    logic [4:0]  rs2f;
    logic [31:0] immI;
    logic [31:0] immSh;
    logic        bad;

    assign f7    = instr.r.funct7;
    assign f3    = instr.r.funct3;
    assign rs2f  = instr.r.rs2;
    assign immI  = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign immSh = {27'b0, instr.r.rs2};   // shamt or bit index

    always_comb begin
        dec        = '0;
        dec.aluOp  = aluAdd;
        dec.funct3 = f3;
        bad        = 1'b0;

        case (instr.r.opcode)
            opOp: begin
                case ({f7, f3})
                    {f7Base, f3AddSub}: dec.aluOp = aluAdd;
                    {f7Alt, f3AddSub}:  dec.aluOp = aluSub;
                    {f7Base, f3Sll}:    dec.aluOp = aluSll;
                    {f7Base, f3Slt}:    dec.aluOp = aluSlt;
                    {f7Base, f3Sltu}:   dec.aluOp = aluSltu;
                    {f7Base, f3Xor}:    dec.aluOp = aluXor;
                    {f7Base, f3Sr}:     dec.aluOp = aluSrl;
                    {f7Alt, f3Sr}:      dec.aluOp = aluSra;
                    {f7Base, f3Or}:     dec.aluOp = aluOr;
                    {f7Base, f3And}:    dec.aluOp = aluAnd;
                    {f7Zba, f3Sh1add},
                    {f7Zba, f3Sh2add},
                    {f7Zba, f3Sh3add}:  dec.aluOp = aluShadd;
                    {f7MinMax, f3Min},
                    {f7MinMax, f3Minu}: dec.aluOp = aluMin;
                    {f7MinMax, f3Max},
                    {f7MinMax, f3Maxu}: dec.aluOp = aluMax;
                    {f7Negate, f3And}:  dec.aluOp = aluAndn;
                    {f7Negate, f3Or}:   dec.aluOp = aluOrn;
                    {f7Negate, f3Xor}:  dec.aluOp = aluXnor;
                    {f7Rotate, f3Sll}:  dec.aluOp = aluRol;
                    {f7Rotate, f3Sr}:   dec.aluOp = aluRor;
                    {f7Bclr, f3Sll}:    dec.aluOp = aluBclr;
                    {f7Bext, f3Sr}:     dec.aluOp = aluBext;
                    {f7Binv, f3Sll}:    dec.aluOp = aluBinv;
                    {f7Bset, f3Sll}:    dec.aluOp = aluBset;
                    {f7Zext, f3Xor}: begin
                        if (rs2f == rs2Zext) dec.aluOp = aluZext;
                        else bad = 1'b1;
                    end
                    default: bad = 1'b1;
                endcase
            end

            opOpImm: begin
                dec.useImm = 1'b1;
                dec.imm    = immI;
                case (f3)
                    f3AddSub: dec.aluOp = aluAdd;
                    f3Slt:    dec.aluOp = aluSlt;
                    f3Sltu:   dec.aluOp = aluSltu;
                    f3Xor:    dec.aluOp = aluXor;
                    f3Or:     dec.aluOp = aluOr;
                    f3And:    dec.aluOp = aluAnd;
                    f3Sll: begin
                        dec.imm = immSh;
                        case (f7)
                            f7Base:   dec.aluOp = aluSll;
                            f7Bclr:   dec.aluOp = aluBclr;
                            f7Binv:   dec.aluOp = aluBinv;
                            f7Bset:   dec.aluOp = aluBset;
                            f7Rotate: begin
                                // sext.b / sext.h, other unary forms unsupported
                                if (rs2f == rs2SextB || rs2f == rs2SextH) dec.aluOp = aluSext;
                                else bad = 1'b1;
                            end
                            default: bad = 1'b1;
                        endcase
                    end
                    f3Sr: begin
                        dec.imm = immSh;
                        case (f7)
                            f7Base:   dec.aluOp = aluSrl;
                            f7Alt:    dec.aluOp = aluSra;
                            f7Rotate: dec.aluOp = aluRor;
                            f7Bext:   dec.aluOp = aluBext;
                            default:  bad = 1'b1;
                        endcase
                    end
                endcase
            end

            opBranch: begin
                dec.isBranch = 1'b1;   // Decision is bit 0 of the compare
                case (f3)
                    f3Beq:   dec.aluOp = aluEq;
                    f3Bne:   dec.aluOp = aluNe;
                    f3Blt:   dec.aluOp = aluSlt;
                    f3Bge:   dec.aluOp = aluSge;
                    f3Bltu:  dec.aluOp = aluSltu;
                    f3Bgeu:  dec.aluOp = aluSgeu;
                    default: bad = 1'b1;
                endcase
            end

            opJalr: begin
                if (f3 == f3Jalr) begin
                    dec.aluOp  = aluJalr;
                    dec.useImm = 1'b1;
                    dec.imm    = immI;
                end else begin
                    bad = 1'b1;
                end
            end

            default: bad = 1'b1;
        endcase

        // Illegal word passes rs1 through as rs1 + 0
        if (bad) begin
            dec.aluOp    = aluAdd;
            dec.useImm   = 1'b1;
            dec.imm      = '0;
            dec.isBranch = 1'b0;
        end
        dec.illegal = bad;
    end

endmodule

`default_nettype wire

//--- alu/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  logic [31:0]    opA,
    input  logic [31:0]    opB,
    input  aluPkg::aluOp_e aluOp,
    input  logic [2:0]     funct3,
    output logic [31:0]    result
);

    import rvPkg::*;
    import aluPkg::*;

    logic [4:0]  shamt;
    logic [5:0]  shInv;
    logic [31:0] bitMask;
    logic        ltS;
    logic        ltU;

    assign shamt   = opB[4:0];                 // RV32 uses low 5 bits only
    assign shInv   = 6'd32 - {1'b0, shamt};    // 32 when shamt is 0, shifts out fully
    assign bitMask = 32'd1 << shamt;
    assign ltS     = $signed(opA) < $signed(opB);
    assign ltU     = opA < opB;

    always_comb begin
        case (aluOp)
            aluAdd:  result = opA + opB;
            aluSub:  result = opA - opB;
            aluAnd:  result = opA & opB;
            aluOr:   result = opA | opB;
            aluXor:  result = opA ^ opB;
            aluSll:  result = opA << shamt;
            aluSrl:  result = opA >> shamt;
            aluSra:  result = $signed(opA) >>> shamt;

            // Compares also drive the branch decision
            aluSlt:  result = {31'b0, ltS};
            aluSge:  result = {31'b0, ~ltS};
            aluSltu: result = {31'b0, ltU};
            aluSgeu: result = {31'b0, ~ltU};
            aluEq:   result = {31'b0, opA == opB};
            aluNe:   result = {31'b0, opA != opB};

            aluJalr: result = (opA + opB) & ~32'd1;

            aluShadd: begin
                case (funct3)
                    f3Sh1add: result = (opA << 1) + opB;
                    f3Sh2add: result = (opA << 2) + opB;
                    f3Sh3add: result = (opA << 3) + opB;
                    default:  result = '0;
                endcase
            end

            aluAndn: result = opA & ~opB;
            aluOrn:  result = opA | ~opB;
            aluXnor: result = ~(opA ^ opB);

            aluMax: begin
                case (funct3)
                    f3Max:   result = ltS ? opB : opA;
                    f3Maxu:  result = ltU ? opB : opA;
                    default: result = '0;
                endcase
            end
            aluMin: begin
                case (funct3)
                    f3Min:   result = ltS ? opA : opB;
                    f3Minu:  result = ltU ? opA : opB;
                    default: result = '0;
                endcase
            end

            aluSext: begin
                case (shamt)
                    rs2SextB: result = {{24{opA[7]}}, opA[7:0]};
                    rs2SextH: result = {{16{opA[15]}}, opA[15:0]};
                    default:  result = '0;
                endcase
            end
            aluZext: result = {16'b0, opA[15:0]};

            aluRol:  result = (opA << shamt) | (opA >> shInv);
            aluRor:  result = (opA >> shamt) | (opA << shInv);

            // Zbs, register and immediate forms share one code
            aluBclr: result = opA & ~bitMask;
            aluBext: result = {31'b0, opA[shamt]};
            aluBinv: result = opA ^ bitMask;
            aluBset: result = opA | bitMask;

            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  logic [31:0]      rs1Val,
    input  logic [31:0]      rs2Val,
    input  aluPkg::decoded_s dec,
    output logic             outValid,
    output aluPkg::execOut_s outData
);

    import aluPkg::*;

    logic [31:0] opB;
    logic [31:0] aluResult;
    execOut_s    nextOut;

    assign opB = dec.useImm ? dec.imm : rs2Val;

    alu uAlu (
        .opA    (rs1Val),
        .opB    (opB),
        .aluOp  (dec.aluOp),
        .funct3 (dec.funct3),
        .result (aluResult)
    );

    // Result is kept for branches and illegal words too
    always_comb begin
        nextOut.result      = aluResult;
        nextOut.branchTaken = dec.isBranch & aluResult[0];
        nextOut.illegal     = dec.illegal;
    end

    // One cycle latency, new input every cycle
    always_ff @(posedge clk) begin
        if (!rstN) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else begin
            outValid <= inValid;
            if (inValid) outData <= nextOut;   // Hold last result when idle
        end
    end

endmodule

`default_nettype wire

//--- verilog/execUnit.sv
`timescale 1ns/1ns
`default_nettype none

module execUnit (
    input  logic             clk,
    input  logic             rstN,
    input  logic             inValid,
    input  aluPkg::execIn_s  inData,
    output logic             outValid,
    output aluPkg::execOut_s outData
);

    import aluPkg::*;

    decoded_s dec;   // Decoder to stage, same cycle

    aluDecoder uDecoder (
        .instr (inData.instr),
        .dec   (dec)
    );

    executeStage uStage (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .rs1Val   (inData.rs1Val),
        .rs2Val   (inData.rs2Val),
        .dec      (dec),
        .outValid (outValid),
        .outData  (outData)
    );

endmodule

`default_nettype wire

//--- dv/clkGen.sv
`timescale 1ns/1ns
`default_nettype none

module clkGen (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod  = 10;   // 20 ns clock
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Released on a rising edge, like any other driven input
    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/execProps_props.sv
`timescale 1ns/1ns
`default_nettype none

module execProps (
    input logic             clk,
    input logic             rstN,
    input logic             inValid,
    input logic             outValid,
    input aluPkg::decoded_s dec,
    input aluPkg::execOut_s outData
);

    logic seenInput;   // Set by the first accepted item

    always @(posedge clk) begin
        if (!rstN) seenInput <= 1'b0;
        else if (inValid) seenInput <= 1'b1;
    end

    idleBeforeInput: assert property (@(posedge clk) rstN && !seenInput |-> !outValid)
        else $error("outValid high before any input was accepted");

    // One cycle latency, no gaps and no extra outputs
    validFollows: assert property (@(posedge clk) disable iff (!rstN)
        rstN |=> (outValid == $past(inValid)))
        else $error("outValid does not follow inValid by one cycle");

    branchOnlyOnBranch: assert property (@(posedge clk) disable iff (!rstN)
        inValid && !dec.isBranch |=> !outData.branchTaken)
        else $error("branchTaken high for a non-branch instruction");

endmodule

bind executeStage execProps uProps (
    .clk      (clk),
    .rstN     (rstN),
    .inValid  (inValid),
    .outValid (outValid),
    .dec      (dec),
    .outData  (outData)
);

`default_nettype wire

//--- dv/execTb.sv
`timescale 1ns/1ns
`default_nettype none

module execTb;

    import rvPkg::*;
    import aluPkg::*;

    localparam int numTests   = 600;
    localparam int watchdogNs = (numTests + 20) * 20;

    // {funct7, funct3} of the Zbb register forms, zext.h is the last one
    localparam logic [9:0] zbbReg [10] = '{
        {f7Negate, f3And}, {f7Negate, f3Or}, {f7Negate, f3Xor}, {f7MinMax, f3Min},
        {f7MinMax, f3Minu}, {f7MinMax, f3Max}, {f7MinMax, f3Maxu}, {f7Rotate, f3Sll},
        {f7Rotate, f3Sr}, {f7Zext, f3Xor}
    };
    localparam logic [9:0] zbsOps [4] = '{
        {f7Bclr, f3Sll}, {f7Bext, f3Sr}, {f7Binv, f3Sll}, {f7Bset, f3Sll}
    };
    localparam logic [2:0] shaddF3 [3] = '{f3Sh1add, f3Sh2add, f3Sh3add};

    logic        clk;
    logic        rstN;
    logic        inValid;
    execIn_s     inData;
    logic        outValid;
    execOut_s    outData;
    logic        expValid;
    execOut_s    expOut;
    execIn_s     expIn;       // Item behind expOut, for messages
    logic [31:0] lfsrState;

    clkGen uClk (
        .clk  (clk),
        .rstN (rstN)
    );

    execUnit dut (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .inData   (inData),
        .outValid (outValid),
        .outData  (outData)
    );

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsrState = lfsrNext(lfsrState);
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] rotl(input logic [31:0] v, input logic [4:0] n);
        logic [31:0] w;
        w = v;
        for (int k = 0; k < 32; k++) begin
            if (k < int'(n)) w = {w[30:0], w[31]};   // One bit at a time
        end
        return w;
    endfunction

    // Register forms, ok drops for anything outside base, Zba, Zbb, Zbs
    function automatic logic [31:0] regOp(input rType_s r, input logic [31:0] a,
                                          input logic [31:0] b, output logic ok);
        logic [4:0] sh;
        logic       lt;
        logic       ltu;
        sh  = b[4:0];
        lt  = $signed(a) < $signed(b);
        ltu = a < b;
        ok  = 1'b1;
        case ({r.funct7, r.funct3})
            {f7Base, f3AddSub}:   return a + b;
            {f7Alt, f3AddSub}:    return a - b;
            {f7Base, f3Sll}:      return a << sh;
            {f7Base, f3Slt}:      return {31'b0, lt};
            {f7Base, f3Sltu}:     return {31'b0, ltu};
            {f7Base, f3Xor}:      return a ^ b;
            {f7Base, f3Sr}:       return a >> sh;
            {f7Alt, f3Sr}:        return $signed(a) >>> sh;
            {f7Base, f3Or}:       return a | b;
            {f7Base, f3And}:      return a & b;
            {f7Zba, f3Sh1add}:    return (a << 1) + b;
            {f7Zba, f3Sh2add}:    return (a << 2) + b;
            {f7Zba, f3Sh3add}:    return (a << 3) + b;
            {f7MinMax, f3Min}:    return lt ? a : b;
            {f7MinMax, f3Minu}:   return ltu ? a : b;
            {f7MinMax, f3Max}:    return lt ? b : a;
            {f7MinMax, f3Maxu}:   return ltu ? b : a;
            {f7Negate, f3And}:    return a & ~b;
            {f7Negate, f3Or}:     return a | ~b;
            {f7Negate, f3Xor}:    return ~(a ^ b);
            {f7Rotate, f3Sll}:    return rotl(a, sh);
            {f7Rotate, f3Sr}:     return rotl(a, 5'(32 - int'(sh)));
            {f7Bclr, f3Sll}:      return a & ~(32'd1 << sh);
            {f7Bext, f3Sr}:       return {31'b0, a[sh]};
            {f7Binv, f3Sll}:      return a ^ (32'd1 << sh);
            {f7Bset, f3Sll}:      return a | (32'd1 << sh);
            {f7Zext, f3Xor}: begin
                if (r.rs2 == rs2Zext) return {16'b0, a[15:0]};
                ok = 1'b0;
            end
            default: ok = 1'b0;
        endcase
        return a;
    endfunction

    function automatic logic [31:0] immOp(input rvInstr_u w, input logic [31:0] a,
                                          output logic ok);
        logic [31:0] imm;
        logic [4:0]  sh;
        imm = {{20{w.i.imm[11]}}, w.i.imm};
        sh  = w.r.rs2;   // Shift amount or bit index
        ok  = 1'b1;
        case (w.i.funct3)
            f3AddSub: return a + imm;
            f3Slt:    return {31'b0, $signed(a) < $signed(imm)};
            f3Sltu:   return {31'b0, a < imm};
            f3Xor:    return a ^ imm;
            f3Or:     return a | imm;
            f3And:    return a & imm;
            f3Sll: begin
                case (w.r.funct7)
                    f7Base: return a << sh;
                    f7Bclr: return a & ~(32'd1 << sh);
                    f7Binv: return a ^ (32'd1 << sh);
                    f7Bset: return a | (32'd1 << sh);
                    f7Rotate: begin
                        if (sh == rs2SextB) return {{24{a[7]}}, a[7:0]};
                        if (sh == rs2SextH) return {{16{a[15]}}, a[15:0]};
                        ok = 1'b0;
                    end
                    default: ok = 1'b0;
                endcase
            end
            f3Sr: begin
                case (w.r.funct7)
                    f7Base:   return a >> sh;
                    f7Alt:    return $signed(a) >>> sh;
                    f7Rotate: return rotl(a, 5'(32 - int'(sh)));
                    f7Bext:   return {31'b0, a[sh]};
                    default:  ok = 1'b0;
                endcase
            end
        endcase
        return a;
    endfunction

    function automatic logic branchCmp(input logic [2:0] f3, input logic [31:0] a,
                                       input logic [31:0] b, output logic ok);
        ok = 1'b1;
        case (f3)
            f3Beq:   return a == b;
            f3Bne:   return a != b;
            f3Blt:   return $signed(a) < $signed(b);
            f3Bge:   return $signed(a) >= $signed(b);
            f3Bltu:  return a < b;
            f3Bgeu:  return a >= b;
            default: ok = 1'b0;
        endcase
        return 1'b0;
    endfunction

    function automatic execOut_s refModel(input execIn_s x);
        execOut_s    o;
        logic        ok;
        logic        taken;
        logic [31:0] immI;
        immI = {{20{x.instr.i.imm[11]}}, x.instr.i.imm};
        o    = '0;
        ok   = 1'b0;
        case (x.instr.r.opcode)
            opOp:    o.result = regOp(x.instr.r, x.rs1Val, x.rs2Val, ok);
            opOpImm: o.result = immOp(x.instr, x.rs1Val, ok);
            opBranch: begin
                taken         = branchCmp(x.instr.b.funct3, x.rs1Val, x.rs2Val, ok);
                o.result      = {31'b0, taken};
                o.branchTaken = taken;
            end
            opJalr: begin
                ok       = (x.instr.i.funct3 == f3Jalr);
                o.result = (x.rs1Val + immI) & 32'hffff_fffe;   // Target with bit 0 cleared
            end
            default: ok = 1'b0;
        endcase
        if (!ok) begin
            o.result      = x.rs1Val;
            o.branchTaken = 1'b0;
        end
        o.illegal = !ok;
        return o;
    endfunction

    // Mostly legal encodings, with a share of bad fields and raw words
    function automatic execIn_s makeItem();
        execIn_s    x;
        logic [4:0] kind;
        logic [3:0] pick;
        logic [1:0] sel;
        x.rs1Val = randBits(32);
        x.rs2Val = randBits(32);
        x.instr  = randBits(32);
        kind     = 5'(randBits(5));
        if (kind < 5'd6) begin
            x.instr.r.opcode = opOp;
            x.instr.r.funct7 = (randBits(1) != 0) ? f7Alt : f7Base;
        end else if (kind < 5'd11) begin
            x.instr.i.opcode = opOpImm;
            if (x.instr.i.funct3 == f3Sll) x.instr.r.funct7 = f7Base;
            if (x.instr.i.funct3 == f3Sr) x.instr.r.funct7 = (randBits(1) != 0) ? f7Alt : f7Base;
        end else if (kind < 5'd13) begin
            x.instr.r.opcode = opOp;
            x.instr.r.funct7 = f7Zba;
            x.instr.r.funct3 = shaddF3[2'(randBits(2) % 3)];
        end else if (kind < 5'd16) begin
            pick = 4'(randBits(4) % 10);
            x.instr.r.opcode = opOp;
            {x.instr.r.funct7, x.instr.r.funct3} = zbbReg[pick];
            if (pick == 4'd9) x.instr.r.rs2 = rs2Zext;
        end else if (kind < 5'd18) begin
            sel = 2'(randBits(2));
            x.instr.i.opcode = opOpImm;
            x.instr.r.funct7 = f7Rotate;
            x.instr.r.funct3 = (sel == 2'd0) ? f3Sr : f3Sll;
            if (sel == 2'd1) x.instr.r.rs2 = rs2SextB;
            if (sel == 2'd2) x.instr.r.rs2 = rs2SextH;   // sel 3 keeps a random rs2
        end else if (kind < 5'd23) begin
            x.instr.r.opcode = (kind < 5'd21) ? opOp : opOpImm;
            {x.instr.r.funct7, x.instr.r.funct3} = zbsOps[2'(randBits(2))];
        end else if (kind < 5'd27) begin
            x.instr.b.opcode = opBranch;
            if (randBits(2) == 0) x.rs2Val = x.rs1Val;   // Equal operands now and then
        end else if (kind < 5'd29) begin
            x.instr.i.opcode = opJalr;
            if (randBits(3) != 0) x.instr.i.funct3 = f3Jalr;
        end else if (kind < 5'd31) begin
            case (2'(randBits(2)))
                2'd0:    x.instr.r.opcode = opOp;
                2'd1:    x.instr.r.opcode = opOpImm;
                2'd2:    x.instr.r.opcode = opBranch;
                default: x.instr.r.opcode = opJalr;
            endcase
        end
        return x;
    endfunction

    task automatic checkValid(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "valid mismatch");
        end
    endtask

    task automatic checkResult(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic checkBranch(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "branch mismatch");
        end
    endtask

    task automatic checkIllegal(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "illegal flag mismatch");
        end
    endtask

    task automatic compareOutputs();
        string what;
        what = $sformatf("instr %h rs1 %h rs2 %h", expIn.instr, expIn.rs1Val, expIn.rs2Val);
        checkValid(outValid, expValid, "outValid");
        if (expValid || !rstN) begin   // Data is defined after reset and on valid
            checkResult(outData.result, expOut.result, {"result for ", what});
            checkBranch(outData.branchTaken, expOut.branchTaken, {"branchTaken for ", what});
            checkIllegal(outData.illegal, expOut.illegal, {"illegal for ", what});
        end
    endtask

    // One-deep model of the output register
    always @(posedge clk) begin
        if (!rstN) begin
            expValid <= 1'b0;
            expOut   <= '0;
            expIn    <= '0;
        end else begin
            expValid <= inValid;
            if (inValid) begin
                expOut <= refModel(inData);
                expIn  <= inData;
            end
        end
    end

    initial begin
        #(watchdogNs);
        $display("Watchdog expired after %0d ns, the run did not finish", watchdogNs);
        $display("Errors found");
        $fatal(1, "timeout");
    end

    initial begin
        lfsrState = 32'h907e8685;
        inValid   = 1'b0;
        inData    = '0;
        @(negedge clk);
        while (!rstN) begin
            compareOutputs();
            @(negedge clk);
        end
        for (int t = 0; t < numTests; t++) begin
            @(posedge clk);
            inValid <= (randBits(2) != 0);   // Mostly back to back
            inData  <= makeItem();
            @(negedge clk);
            compareOutputs();
        end
        @(posedge clk);
        inValid <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            compareOutputs();
        end
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
common/rvPkg.sv
common/aluPkg.sv
decode/aluDecoder.sv
alu/alu.sv
verilog/executeStage.sv
verilog/execUnit.sv
dv/clkGen.sv
dv/execProps_props.sv
dv/execTb.sv

//--- Makefile
VERILATOR = verilator
TOP       = execTb
FILELIST  = sources.f
OBJDIR    = obj_dir
VFLAGS    = --binary --timing --assert -j 0 --Mdir $(OBJDIR)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
